/* hw/axi_rr_pkg.sv */
`default_nettype none

package axi_rr_pkg;

   // axi field widths
   localparam int AXI_ID_W   = 6;
   localparam int AXI_ADDR_W = 64;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_SIZE_W = 3;
   localparam int AXI_DATA_W = 64;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;
   localparam int AXI_RESP_W = 2;

   typedef logic [AXI_ID_W-1:0]   axi_id_t;
   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_LEN_W-1:0]  axi_len_t;
   typedef logic [AXI_SIZE_W-1:0] axi_size_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;
   typedef logic [AXI_STRB_W-1:0] axi_strb_t;
   typedef logic [AXI_RESP_W-1:0] axi_resp_t;

   // write address, 81 bits
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } axi_aw_t;

   // read address, same layout as aw
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } axi_ar_t;

   // write data beat, 79 bits
   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   // write response, 8 bits
   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   // read data beat, 73 bits
   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

   // valid bit positions on the master-to-slave log bus
   localparam int M2S_LOGB_CNT = 3;
   localparam int LOGB_AW      = 0;
   localparam int LOGB_W       = 1;
   localparam int LOGB_AR      = 2;

   // valid bit positions on the slave-to-master log bus
   localparam int S2M_LOGB_CNT = 2;
   localparam int LOGB_B       = 0;
   localparam int LOGB_R       = 1;

   typedef struct packed {
      logic [M2S_LOGB_CNT-1:0] valid;
      axi_aw_t                 aw;
      axi_w_t                  w;
      axi_ar_t                 ar;
   } m2s_logb_t;

   typedef struct packed {
      logic [S2M_LOGB_CNT-1:0] valid;
      axi_b_t                  b;
      axi_r_t                  r;
   } s2m_logb_t;

   // register stages between a handshake and its log record
   localparam int LOG_PIPE_DEPTH = 2;

endpackage

`default_nettype wire

/* hw/axi_channel_logger.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_channel_logger #(
   parameter int PAYLOAD_W = 8
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,

   // upstream side, driven by the source of this channel
   input  logic                 i_in_valid,
   output logic                 o_in_ready,
   input  logic [PAYLOAD_W-1:0] i_in_data,

   // downstream side, towards the sink of this channel
   output logic                 o_out_valid,
   input  logic                 i_out_ready,
   output logic [PAYLOAD_W-1:0] o_out_data,

   // high while the log sink cannot take more records
   input  logic                 i_stall,

   output logic                 o_log_valid,
   output logic [PAYLOAD_W-1:0] o_log_data
);

   localparam int DEPTH = axi_rr_pkg::LOG_PIPE_DEPTH;

   logic                 handshake;
   logic [DEPTH-1:0]     pipe_valid;
   logic [PAYLOAD_W-1:0] pipe_data [DEPTH];

   // pass-through, both directions blocked during a stall
   // so that nothing can complete without being logged
   assign o_out_valid = i_in_valid & ~i_stall;
   assign o_in_ready  = i_out_ready & ~i_stall;
   assign o_out_data  = i_in_data;

   // the source sees o_in_ready, so a transfer completes here
   assign handshake = i_in_valid & o_in_ready;

   // valid shift chain
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= handshake;
         for (int i = 1; i < DEPTH; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
         end
      end
   end

   // payload chain, a stage only loads when a record moves into it
   always_ff @(posedge clk) begin
      if (handshake) begin
         pipe_data[0] <= i_in_data;
      end
      for (int i = 1; i < DEPTH; i++) begin
         if (pipe_valid[i-1]) begin
            pipe_data[i] <= pipe_data[i-1];
         end
      end
   end

   assign o_log_valid = pipe_valid[DEPTH-1];
   assign o_log_data  = pipe_data[DEPTH-1];

   // no valid may appear downstream while the log sink is almost full
   a_no_valid_in_stall : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      $rose(o_out_valid) |-> !i_stall
   ) else $error("out valid rose during stall");

   // the source must not see ready while the log sink is almost full
   a_no_ready_in_stall : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      $rose(o_in_ready) |-> !i_stall
   ) else $error("in ready rose during stall");

   // every completed transfer shows up on the log exactly DEPTH cycles later
   a_log_after_handshake : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      handshake |-> ##DEPTH o_log_valid
   ) else $error("handshake without log record");

   // and no record appears without a transfer behind it, with its payload
   a_log_has_handshake : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      o_log_valid |-> ($past(handshake, DEPTH) &&
                       o_log_data == $past(i_in_data, DEPTH))
   ) else $error("log record without matching handshake");

endmodule

`default_nettype wire

/* hw/axi_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_recorder (
   input  logic                  clk,
   input  logic                  sync_rst_n,

   // master side, AW
   input  axi_rr_pkg::axi_aw_t   i_m_aw,
   input  logic                  i_m_aw_valid,
   output logic                  o_m_aw_ready,
   // master side, W
   input  axi_rr_pkg::axi_w_t    i_m_w,
   input  logic                  i_m_w_valid,
   output logic                  o_m_w_ready,
   // master side, AR
   input  axi_rr_pkg::axi_ar_t   i_m_ar,
   input  logic                  i_m_ar_valid,
   output logic                  o_m_ar_ready,
   // master side, B
   output axi_rr_pkg::axi_b_t    o_m_b,
   output logic                  o_m_b_valid,
   input  logic                  i_m_b_ready,
   // master side, R
   output axi_rr_pkg::axi_r_t    o_m_r,
   output logic                  o_m_r_valid,
   input  logic                  i_m_r_ready,

   // slave side, AW
   output axi_rr_pkg::axi_aw_t   o_s_aw,
   output logic                  o_s_aw_valid,
   input  logic                  i_s_aw_ready,
   // slave side, W
   output axi_rr_pkg::axi_w_t    o_s_w,
   output logic                  o_s_w_valid,
   input  logic                  i_s_w_ready,
   // slave side, AR
   output axi_rr_pkg::axi_ar_t   o_s_ar,
   output logic                  o_s_ar_valid,
   input  logic                  i_s_ar_ready,
   // slave side, B
   input  axi_rr_pkg::axi_b_t    i_s_b,
   input  logic                  i_s_b_valid,
   output logic                  o_s_b_ready,
   // slave side, R
   input  axi_rr_pkg::axi_r_t    i_s_r,
   input  logic                  i_s_r_valid,
   output logic                  o_s_r_ready,

   // log buses towards the sink
   output axi_rr_pkg::m2s_logb_t o_log_m2s,
   input  logic                  i_log_m2s_almful,
   output axi_rr_pkg::s2m_logb_t o_log_s2m,
   input  logic                  i_log_s2m_almful
);

   logic stall;

   logic                aw_log_valid;
   axi_rr_pkg::axi_aw_t aw_log_data;
   logic                w_log_valid;
   axi_rr_pkg::axi_w_t  w_log_data;
   logic                ar_log_valid;
   axi_rr_pkg::axi_ar_t ar_log_data;
   logic                b_log_valid;
   axi_rr_pkg::axi_b_t  b_log_data;
   logic                r_log_valid;
   axi_rr_pkg::axi_r_t  r_log_data;

   // either sink filling up halts every channel, otherwise a write
   // could be logged on one bus while its response is lost on the other
   assign stall = i_log_m2s_almful | i_log_s2m_almful;

   // master to slave channels

   axi_channel_logger #(
      .PAYLOAD_W ($bits(axi_rr_pkg::axi_aw_t))
   ) aw_logger (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .i_in_valid  (i_m_aw_valid),
      .o_in_ready  (o_m_aw_ready),
      .i_in_data   (i_m_aw),
      .o_out_valid (o_s_aw_valid),
      .i_out_ready (i_s_aw_ready),
      .o_out_data  (o_s_aw),
      .i_stall     (stall),
      .o_log_valid (aw_log_valid),
      .o_log_data  (aw_log_data)
   );

   axi_channel_logger #(
      .PAYLOAD_W ($bits(axi_rr_pkg::axi_w_t))
   ) w_logger (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .i_in_valid  (i_m_w_valid),
      .o_in_ready  (o_m_w_ready),
      .i_in_data   (i_m_w),
      .o_out_valid (o_s_w_valid),
      .i_out_ready (i_s_w_ready),
      .o_out_data  (o_s_w),
      .i_stall     (stall),
      .o_log_valid (w_log_valid),
      .o_log_data  (w_log_data)
   );

   axi_channel_logger #(
      .PAYLOAD_W ($bits(axi_rr_pkg::axi_ar_t))
   ) ar_logger (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .i_in_valid  (i_m_ar_valid),
      .o_in_ready  (o_m_ar_ready),
      .i_in_data   (i_m_ar),
      .o_out_valid (o_s_ar_valid),
      .i_out_ready (i_s_ar_ready),
      .o_out_data  (o_s_ar),
      .i_stall     (stall),
      .o_log_valid (ar_log_valid),
      .o_log_data  (ar_log_data)
   );

   // slave to master channels where the slave is the source

   axi_channel_logger #(
      .PAYLOAD_W ($bits(axi_rr_pkg::axi_b_t))
   ) b_logger (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .i_in_valid  (i_s_b_valid),
      .o_in_ready  (o_s_b_ready),
      .i_in_data   (i_s_b),
      .o_out_valid (o_m_b_valid),
      .i_out_ready (i_m_b_ready),
      .o_out_data  (o_m_b),
      .i_stall     (stall),
      .o_log_valid (b_log_valid),
      .o_log_data  (b_log_data)
   );

   axi_channel_logger #(
      .PAYLOAD_W ($bits(axi_rr_pkg::axi_r_t))
   ) r_logger (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .i_in_valid  (i_s_r_valid),
      .o_in_ready  (o_s_r_ready),
      .i_in_data   (i_s_r),
      .o_out_valid (o_m_r_valid),
      .i_out_ready (i_m_r_ready),
      .o_out_data  (o_m_r),
      .i_stall     (stall),
      .o_log_valid (r_log_valid),
      .o_log_data  (r_log_data)
   );

   // pack records onto the two log buses
   always_comb begin
      o_log_m2s = '0;
      o_log_m2s.valid[axi_rr_pkg::LOGB_AW] = aw_log_valid;
      o_log_m2s.valid[axi_rr_pkg::LOGB_W]  = w_log_valid;
      o_log_m2s.valid[axi_rr_pkg::LOGB_AR] = ar_log_valid;
      o_log_m2s.aw = aw_log_data;
      o_log_m2s.w  = w_log_data;
      o_log_m2s.ar = ar_log_data;
   end

   always_comb begin
      o_log_s2m = '0;
      o_log_s2m.valid[axi_rr_pkg::LOGB_B] = b_log_valid;
      o_log_s2m.valid[axi_rr_pkg::LOGB_R] = r_log_valid;
      o_log_s2m.b = b_log_data;
      o_log_s2m.r = r_log_data;
   end

endmodule

`default_nettype wire

/* include/tb_axi_rr_model.svh */
`ifndef TB_AXI_RR_MODEL_SVH
`define TB_AXI_RR_MODEL_SVH

// channel numbering inside the model
localparam int CH_AW = 0;
localparam int CH_W  = 1;
localparam int CH_AR = 2;
localparam int CH_B  = 3;
localparam int CH_R  = 4;
localparam int N_CH  = 5;

// widest payload is aw/ar, everything else is zero extended
localparam int REC_W = $bits(axi_rr_pkg::axi_aw_t);

typedef struct packed {
   int               due;
   logic [REC_W-1:0] data;
} exp_rec_t;

// records waiting for their log pulse, oldest first
exp_rec_t exp_q [N_CH][$];

// a record carries the transferred payload, only the channel's own bits
function automatic logic [REC_W-1:0] expected_record(input logic [REC_W-1:0] payload,
                                                     input int width);
   logic [REC_W-1:0] rec;
   for (int i = 0; i < REC_W; i++) begin
      rec[i] = (i < width) ? payload[i] : 1'b0;
   end
   return rec;
endfunction

task automatic push_expected(input int ch, input logic [REC_W-1:0] payload,
                             input int width, input int cycle);
   exp_rec_t rec;
   rec.due  = cycle + axi_rr_pkg::LOG_PIPE_DEPTH;
   rec.data = expected_record(payload, width);
   exp_q[ch].push_back(rec);
endtask

task automatic check_log(input int ch, input string name, input logic valid,
                         input logic [REC_W-1:0] data, input int cycle);
   exp_rec_t rec;
   if (valid === 1'b1) begin
      if (exp_q[ch].size() == 0) begin
         stop_on_error($sformatf("log pulse on %s in cycle %0d without a handshake",
                                 name, cycle));
      end else begin
         rec = exp_q[ch].pop_front();
         check_value({name, " record cycle"}, rec.due, cycle);
         check_value({name, " record payload"}, rec.data, data);
      end
   end else if (exp_q[ch].size() != 0 && exp_q[ch][0].due <= cycle) begin
      stop_on_error($sformatf("record on %s due in cycle %0d never appeared",
                              name, exp_q[ch][0].due));
   end
endtask

function automatic bit queues_empty();
   for (int ch = 0; ch < N_CH; ch++) begin
      if (exp_q[ch].size() != 0) begin
         return 1'b0;
      end
   end
   return 1'b1;
endfunction

`endif

/* test/tb_axi_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_recorder;

   localparam int CLK_PERIOD = 8;
   localparam int N_CYCLES   = 2000;
   localparam int N_DIRECTED = 24;
   localparam int N_DRAIN    = 8;
   localparam int N_RANDOM   = N_CYCLES - N_DIRECTED - N_DRAIN;

   logic clk = 1'b0;
   logic sync_rst_n;
   int   seed = 32'h698b9c0f;
   int   cycle = 0;
   int   almful_left = 0;
   logic [1:0] almful_sel = 2'b00;

   axi_rr_pkg::axi_aw_t   i_m_aw, o_s_aw;
   axi_rr_pkg::axi_w_t    i_m_w, o_s_w;
   axi_rr_pkg::axi_ar_t   i_m_ar, o_s_ar;
   axi_rr_pkg::axi_b_t    i_s_b, o_m_b;
   axi_rr_pkg::axi_r_t    i_s_r, o_m_r;
   logic i_m_aw_valid, o_m_aw_ready, o_s_aw_valid, i_s_aw_ready;
   logic i_m_w_valid, o_m_w_ready, o_s_w_valid, i_s_w_ready;
   logic i_m_ar_valid, o_m_ar_ready, o_s_ar_valid, i_s_ar_ready;
   logic i_s_b_valid, o_s_b_ready, o_m_b_valid, i_m_b_ready;
   logic i_s_r_valid, o_s_r_ready, o_m_r_valid, i_m_r_ready;
   axi_rr_pkg::m2s_logb_t o_log_m2s;
   axi_rr_pkg::s2m_logb_t o_log_s2m;
   logic i_log_m2s_almful, i_log_s2m_almful;

   axi_recorder UUT (.*);

   `include "tb_axi_rr_model.svh"

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
      end
   endtask

   function automatic logic [95:0] random_bits();
      return {$random(seed), $random(seed), $random(seed)};
   endfunction

   // either sink almost full halts the whole link
   function automatic logic sink_full();
      return i_log_m2s_almful | i_log_s2m_almful;
   endfunction

   task automatic drive_payloads();
      logic [95:0] r;
      r = random_bits();
      i_m_aw <= r[$bits(axi_rr_pkg::axi_aw_t)-1:0];
      r = random_bits();
      i_m_w <= r[$bits(axi_rr_pkg::axi_w_t)-1:0];
      r = random_bits();
      i_m_ar <= r[$bits(axi_rr_pkg::axi_ar_t)-1:0];
      r = random_bits();
      i_s_b <= r[$bits(axi_rr_pkg::axi_b_t)-1:0];
      r = random_bits();
      i_s_r <= r[$bits(axi_rr_pkg::axi_r_t)-1:0];
   endtask

   task automatic drive_handshake(input logic [4:0] valid, input logic [4:0] ready,
                                  input logic m2s_almful, input logic s2m_almful);
      {i_m_aw_valid, i_m_w_valid, i_m_ar_valid, i_s_b_valid, i_s_r_valid} <= valid;
      {i_s_aw_ready, i_s_w_ready, i_s_ar_ready, i_m_b_ready, i_m_r_ready} <= ready;
      i_log_m2s_almful <= m2s_almful;
      i_log_s2m_almful <= s2m_almful;
   endtask

   task automatic drive_random();
      logic [4:0] valid;
      logic [4:0] ready;
      drive_payloads();
      for (int i = 0; i < 5; i++) begin
         valid[i] = $random(seed) & 1;
         ready[i] = ($random(seed) & 3) != 0;
      end
      // almful comes in short bursts on one or both buses
      if (almful_left > 0) begin
         almful_left--;
      end else if (($random(seed) & 31) == 0) begin
         almful_left = 1 + ($unsigned($random(seed)) % 6);
         almful_sel  = 2'(1 + ($unsigned($random(seed)) % 3));
      end
      drive_handshake(valid, ready, almful_left > 0 && almful_sel[0],
                      almful_left > 0 && almful_sel[1]);
   endtask

   task automatic check_passthrough();
      logic stall;
      stall = sink_full();
      check_value("aw payload", i_m_aw, o_s_aw);
      check_value("aw valid", i_m_aw_valid && !stall, o_s_aw_valid);
      check_value("aw ready", i_s_aw_ready && !stall, o_m_aw_ready);
      check_value("w payload", i_m_w, o_s_w);
      check_value("w valid", i_m_w_valid && !stall, o_s_w_valid);
      check_value("w ready", i_s_w_ready && !stall, o_m_w_ready);
      check_value("ar payload", i_m_ar, o_s_ar);
      check_value("ar valid", i_m_ar_valid && !stall, o_s_ar_valid);
      check_value("ar ready", i_s_ar_ready && !stall, o_m_ar_ready);
      check_value("b payload", i_s_b, o_m_b);
      check_value("b valid", i_s_b_valid && !stall, o_m_b_valid);
      check_value("b ready", i_m_b_ready && !stall, o_s_b_ready);
      check_value("r payload", i_s_r, o_m_r);
      check_value("r valid", i_s_r_valid && !stall, o_m_r_valid);
      check_value("r ready", i_m_r_ready && !stall, o_s_r_ready);
      if (stall) begin
         check_value("stall valids", '0,
                     {o_s_aw_valid, o_s_w_valid, o_s_ar_valid, o_m_b_valid, o_m_r_valid});
         check_value("stall readies", '0,
                     {o_m_aw_ready, o_m_w_ready, o_m_ar_ready, o_s_b_ready, o_s_r_ready});
      end
   endtask

   // compare at the falling edge, inputs and combinational outputs are settled
   always @(negedge clk) begin
      if (!sync_rst_n) begin
         check_value("reset m2s log valid", '0, o_log_m2s.valid);
         check_value("reset s2m log valid", '0, o_log_s2m.valid);
      end else begin
         check_passthrough();
         check_log(CH_AW, "aw", o_log_m2s.valid[axi_rr_pkg::LOGB_AW], o_log_m2s.aw, cycle);
         check_log(CH_W, "w", o_log_m2s.valid[axi_rr_pkg::LOGB_W], o_log_m2s.w, cycle);
         check_log(CH_AR, "ar", o_log_m2s.valid[axi_rr_pkg::LOGB_AR], o_log_m2s.ar, cycle);
         check_log(CH_B, "b", o_log_s2m.valid[axi_rr_pkg::LOGB_B], o_log_s2m.b, cycle);
         check_log(CH_R, "r", o_log_s2m.valid[axi_rr_pkg::LOGB_R], o_log_s2m.r, cycle);
         // transfers that complete at the coming rising edge
         if (i_m_aw_valid && i_s_aw_ready && !sink_full())
            push_expected(CH_AW, i_m_aw, $bits(axi_rr_pkg::axi_aw_t), cycle);
         if (i_m_w_valid && i_s_w_ready && !sink_full())
            push_expected(CH_W, i_m_w, $bits(axi_rr_pkg::axi_w_t), cycle);
         if (i_m_ar_valid && i_s_ar_ready && !sink_full())
            push_expected(CH_AR, i_m_ar, $bits(axi_rr_pkg::axi_ar_t), cycle);
         if (i_s_b_valid && i_m_b_ready && !sink_full())
            push_expected(CH_B, i_s_b, $bits(axi_rr_pkg::axi_b_t), cycle);
         if (i_s_r_valid && i_m_r_ready && !sink_full())
            push_expected(CH_R, i_s_r, $bits(axi_rr_pkg::axi_r_t), cycle);
      end
   end

   initial begin
      sync_rst_n = 1'b0;
      {i_m_aw, i_m_w, i_m_ar, i_s_b, i_s_r} = '0;
      {i_m_aw_valid, i_m_w_valid, i_m_ar_valid, i_s_b_valid, i_s_r_valid} = '0;
      {i_s_aw_ready, i_s_w_ready, i_s_ar_ready, i_m_b_ready, i_m_r_ready} = '0;
      i_log_m2s_almful = 1'b0;
      i_log_s2m_almful = 1'b0;
      repeat (3) @(posedge clk);
      sync_rst_n <= 1'b1;
      for (int n = 0; n < N_RANDOM; n++) begin
         @(posedge clk);
         drive_random();
      end
      // back to back transfers on every channel
      for (int n = 0; n < N_DIRECTED - 8; n++) begin
         @(posedge clk);
         drive_payloads();
         drive_handshake('1, '1, 1'b0, 1'b0);
      end
      // almful rises with records still in the pipeline
      for (int n = 0; n < 4; n++) begin
         @(posedge clk);
         drive_payloads();
         drive_handshake('1, '1, 1'b1, 1'b0);
      end
      for (int n = 0; n < 4; n++) begin
         @(posedge clk);
         drive_payloads();
         drive_handshake('1, '1, 1'b0, 1'b1);
      end
      for (int n = 0; n < N_DRAIN; n++) begin
         @(posedge clk);
         drive_handshake('0, '1, 1'b0, 1'b0);
      end
      @(posedge clk);
      if (queues_empty()) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         stop_on_error("log records still pending at the end of the run");
      end
   end

   initial begin
      #(2 * N_CYCLES * CLK_PERIOD);
      stop_on_error("watchdog expired before the run finished");
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hw/axi_rr_pkg.sv
hw/axi_channel_logger.sv
hw/axi_recorder.sv
test/tb_axi_recorder.sv

/* Bender.yml */
package:
  name: axi_recorder

sources:
  - hw/axi_rr_pkg.sv
  - hw/axi_channel_logger.sv
  - hw/axi_recorder.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_axi_recorder.sv
